// File: logic/f2_bus_pkg.sv
package f2_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths

    localparam int CPU_AW = 23;     // 68000 word address
    localparam int SDR_AW = 27;     // SDRAM byte address

    ////////////////////////////////////////////////////////////////////////////
    // Chip-select regions

    typedef enum logic [2:0] {
        REG_NONE,
        REG_ROM,
        REG_WORK,
        REG_COLOR,
        REG_IO,
        REG_SOUND,
        REG_SCREEN,
        REG_OBJECT
    } region_t;

    ////////////////////////////////////////////////////////////////////////////
    // Byte address views

    // Memory map view
    typedef struct packed {
        logic [3:0]  region;        // A23..A20
        logic [7:0]  sub;           // A19..A12
        logic [11:0] offset;
    } mem_view_t;

    // Interrupt acknowledge view, level sits on A3..A1
    typedef struct packed {
        logic [19:0] unused;
        logic [2:0]  level;
        logic        lane;          // A0, always zero
    } iack_view_t;

    typedef union packed {
        mem_view_t  mem;
        iack_view_t iack;
    } bus_addr_t;

endpackage

// File: logic/cpu_addr_decoder.sv
`timescale 1ns/1ps

module cpu_addr_decoder
    import f2_bus_pkg::*;
(
    input  logic [CPU_AW-1:0] cpu_addr,
    input  logic [1:0]        cpu_ds_n,
    output region_t           region
);

    bus_addr_t addr;

    assign addr = {cpu_addr, 1'b0};

    ////////////////////////////////////////////////////////////////////////////
    // Region decode

    // Only decoded while a strobe is low
    always_comb begin
        region = REG_NONE;
        if (~&cpu_ds_n) begin
            priority case (addr.mem.region)
                4'h0: region = REG_ROM;
                4'h1: region = REG_WORK;
                4'h2: region = REG_COLOR;
                4'h3: begin
                    // 30xxxx and 32xxxx share the nibble
                    if (addr.mem.sub[7:4] == 4'h0) begin
                        region = REG_IO;
                    end else if (addr.mem.sub[7:4] == 4'h2) begin
                        region = REG_SOUND;
                    end else begin
                        region = REG_NONE;
                    end
                end
                4'h8: region = REG_SCREEN;
                4'h9: region = REG_OBJECT;
                default: region = REG_NONE;
            endcase
        end
    end

endmodule

// File: logic/irq_controller.sv
`timescale 1ns/1ps

module irq_controller
    import f2_bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    input  logic [CPU_AW-1:0] cpu_addr,
    input  logic [1:0]        cpu_ds_n,
    input  logic [2:0]        cpu_fc,

    input  logic              vbl_n,
    input  logic              dma_n,

    output logic [2:0]        ipl_n,
    output logic              vpa_n
);

    bus_addr_t ack_addr;

    logic vbl_s, vbl_prev;
    logic dma_s, dma_prev;
    logic pend5, pend6;
    logic iack;
    logic clr5, clr6;

    assign ack_addr = {cpu_addr, 1'b0};

    assign iack  = &cpu_fc;         // FC = 7
    assign vpa_n = ~iack;           // Autovector

    assign clr5 = iack & ~cpu_ds_n[0] & (ack_addr.iack.level == 3'd5);
    assign clr6 = iack & ~cpu_ds_n[0] & (ack_addr.iack.level == 3'd6);

    ////////////////////////////////////////////////////////////////////////////
    // Edge history

    always_ff @(posedge clk) begin
        if (reset) begin
            vbl_s    <= vbl_n;      // No edge at reset release
            vbl_prev <= vbl_n;
            dma_s    <= dma_n;
            dma_prev <= dma_n;
        end else begin
            vbl_s    <= vbl_n;
            vbl_prev <= vbl_s;
            dma_s    <= dma_n;
            dma_prev <= dma_s;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pending levels

    always_ff @(posedge clk) begin
        if (reset) begin
            pend5 <= 1'b0;
            pend6 <= 1'b0;
        end else begin
            if (vbl_prev & ~vbl_s) pend5 <= 1'b1;   // Falling vblank
            if (~dma_prev & dma_s) pend6 <= 1'b1;   // Rising DMA
            if (clr5) pend5 <= 1'b0;
            if (clr6) pend6 <= 1'b0;
        end
    end

    assign ipl_n = pend6 ? ~3'd6 :
                   pend5 ? ~3'd5 :
                   3'b111;

endmodule

// File: logic/bus_responder.sv
`timescale 1ns/1ps

module bus_responder
    import f2_bus_pkg::*;
#(
    parameter logic [SDR_AW-1:0] ROM_SDR_BASE  = '0,
    parameter logic [SDR_AW-1:0] WORK_SDR_BASE = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  region_t           region,
    input  logic [CPU_AW-1:0] cpu_addr,
    input  logic [1:0]        cpu_ds_n,
    input  logic              cpu_rw,
    input  logic [15:0]       cpu_data_out,

    input  logic [15:0]       sdr_q,
    input  logic              sdr_ack,
    output logic [SDR_AW-1:0] sdr_addr,
    output logic [15:0]       sdr_data,
    output logic [1:0]        sdr_be,
    output logic              sdr_rw,
    output logic              sdr_req,

    input  logic [15:0]       scn_dout,
    input  logic [15:0]       obj_dout,
    input  logic [15:0]       pri_dout,
    input  logic [7:0]        io_dout,
    input  logic [3:0]        snd_dout,

    input  logic              scn_dtack_n,
    input  logic              pri_dtack_n,
    input  logic              obj_busy,

    output logic [15:0]       cpu_data_in,
    output logic              dtack_n
);

    logic              ds_idle_q;
    logic              new_cycle;
    logic              sdr_sel;
    logic              sdr_start;
    logic              sdr_wait;
    logic [SDR_AW-1:0] byte_addr;
    logic [SDR_AW-1:0] sdr_base;

    assign new_cycle = ds_idle_q & ~&cpu_ds_n;
    assign sdr_sel   = (region == REG_ROM) || (region == REG_WORK);
    assign sdr_start = new_cycle & sdr_sel;

    assign byte_addr = {{(SDR_AW - CPU_AW - 1){1'b0}}, cpu_addr, 1'b0};
    assign sdr_base  = (region == REG_WORK) ? WORK_SDR_BASE : ROM_SDR_BASE;

    ////////////////////////////////////////////////////////////////////////////
    // SDRAM toggle request

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_idle_q <= 1'b1;
            sdr_req   <= 1'b0;
        end else begin
            ds_idle_q <= &cpu_ds_n;
            if (sdr_start) sdr_req <= ~sdr_req;
        end
    end

    // Held from the toggle until ack matches
    always_ff @(posedge clk) begin
        if (sdr_start) begin
            sdr_addr <= sdr_base + byte_addr;
            sdr_data <= cpu_data_out;
            sdr_be   <= ~cpu_ds_n;
            sdr_rw   <= cpu_rw;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // DTACK and read data

    // A request about to be issued counts as outstanding
    assign sdr_wait = (sdr_req != sdr_ack) | sdr_start;

    assign dtack_n = (&cpu_ds_n)                            // No cycle in progress
                   | sdr_wait
                   | ((region == REG_SCREEN) & scn_dtack_n)
                   | ((region == REG_COLOR)  & pri_dtack_n)
                   | ((region == REG_OBJECT) & obj_busy);   // Object RAM hold-off

    always_comb begin
        case (region)
            REG_ROM,
            REG_WORK:   cpu_data_in = sdr_q;
            REG_SCREEN: cpu_data_in = scn_dout;
            REG_OBJECT: cpu_data_in = obj_dout;
            REG_COLOR:  cpu_data_in = pri_dout;
            REG_IO:     cpu_data_in = {8'd0, io_dout};
            REG_SOUND:  cpu_data_in = {4'd0, snd_dout, 8'd0};   // D11..D8 only
            default:    cpu_data_in = 16'd0;
        endcase
    end

endmodule

// File: logic/f2_cpu_bus.sv
`timescale 1ns/1ps

module f2_cpu_bus
    import f2_bus_pkg::*;
#(
    parameter logic [SDR_AW-1:0] ROM_SDR_BASE  = '0,
    parameter logic [SDR_AW-1:0] WORK_SDR_BASE = '0
) (
    input  logic              clk,
    input  logic              reset,

    // 68000 bus
    input  logic [CPU_AW-1:0] cpu_addr,
    input  logic [1:0]        cpu_ds_n,
    input  logic              cpu_rw,
    input  logic [2:0]        cpu_fc,
    input  logic [15:0]       cpu_data_out,
    output logic [15:0]       cpu_data_in,
    output logic              dtack_n,
    output logic [2:0]        ipl_n,
    output logic              vpa_n,

    // SDRAM port for ROM and work RAM
    output logic [SDR_AW-1:0] sdr_addr,
    output logic [15:0]       sdr_data,
    output logic [1:0]        sdr_be,
    output logic              sdr_rw,
    output logic              sdr_req,
    input  logic [15:0]       sdr_q,
    input  logic              sdr_ack,

    // Peripheral chips
    input  logic [15:0]       scn_dout,
    input  logic              scn_dtack_n,
    input  logic [15:0]       obj_dout,
    input  logic              obj_busy,
    input  logic [15:0]       pri_dout,
    input  logic              pri_dtack_n,
    input  logic [7:0]        io_dout,
    input  logic [3:0]        snd_dout,

    // Interrupt sources
    input  logic              vbl_n,
    input  logic              dma_n
);

    region_t region;

    cpu_addr_decoder u_decoder (
        .cpu_addr (cpu_addr),
        .cpu_ds_n (cpu_ds_n),
        .region   (region)
    );

    irq_controller u_irq (
        .clk      (clk),
        .reset    (reset),
        .cpu_addr (cpu_addr),
        .cpu_ds_n (cpu_ds_n),
        .cpu_fc   (cpu_fc),
        .vbl_n    (vbl_n),
        .dma_n    (dma_n),
        .ipl_n    (ipl_n),
        .vpa_n    (vpa_n)
    );

    bus_responder #(
        .ROM_SDR_BASE  (ROM_SDR_BASE),
        .WORK_SDR_BASE (WORK_SDR_BASE)
    ) u_resp (
        .clk          (clk),
        .reset        (reset),
        .region       (region),
        .cpu_addr     (cpu_addr),
        .cpu_ds_n     (cpu_ds_n),
        .cpu_rw       (cpu_rw),
        .cpu_data_out (cpu_data_out),
        .sdr_q        (sdr_q),
        .sdr_ack      (sdr_ack),
        .sdr_addr     (sdr_addr),
        .sdr_data     (sdr_data),
        .sdr_be       (sdr_be),
        .sdr_rw       (sdr_rw),
        .sdr_req      (sdr_req),
        .scn_dout     (scn_dout),
        .obj_dout     (obj_dout),
        .pri_dout     (pri_dout),
        .io_dout      (io_dout),
        .snd_dout     (snd_dout),
        .scn_dtack_n  (scn_dtack_n),
        .pri_dtack_n  (pri_dtack_n),
        .obj_busy     (obj_busy),
        .cpu_data_in  (cpu_data_in),
        .dtack_n      (dtack_n)
    );

endmodule

// File: verif/tb_f2_cpu_bus.sv
`timescale 1ns/1ps

module tb_f2_cpu_bus
    import f2_bus_pkg::*;
();

    localparam logic [SDR_AW-1:0] ROM_BASE  = 27'h040_0000;
    localparam logic [SDR_AW-1:0] WORK_BASE = 27'h100_0000;
    localparam logic [31:0]       SEED      = 32'h4cf6_a6aa;
    localparam int                TIMEOUT   = 64;

    logic              clk, reset;
    logic [CPU_AW-1:0] cpu_addr;
    logic [1:0]        cpu_ds_n, sdr_be;
    logic [2:0]        cpu_fc, ipl_n;
    logic              cpu_rw, dtack_n, vpa_n;
    logic [15:0]       cpu_data_out, cpu_data_in;
    logic [SDR_AW-1:0] sdr_addr;
    logic [15:0]       sdr_data, sdr_q;
    logic              sdr_rw, sdr_req, sdr_ack;
    logic [15:0]       scn_dout, obj_dout, pri_dout;
    logic [7:0]        io_dout;
    logic [3:0]        snd_dout;
    logic              scn_dtack_n, pri_dtack_n, obj_busy, vbl_n, dma_n;

    logic [31:0] rng;
    logic        req_seen;
    int          toggles;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    f2_cpu_bus #(.ROM_SDR_BASE(ROM_BASE), .WORK_SDR_BASE(WORK_BASE)) u_dut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic roll(output logic [31:0] r);
        rng = xorshift(rng);
        r = rng;
    endtask

    // Word the SDRAM model returns for an address
    function automatic logic [15:0] sdram_word(input logic [SDR_AW-1:0] a);
        return a[15:0] ^ {a[26:16], 5'h15};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERR time %0t %s expected %0h actual %0h", $time, name, exp, act);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s mismatch", name);
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp) else report_mismatch(name, exp, act);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus-level checks

    assert property (@(negedge clk) disable iff (reset) (sdr_req != sdr_ack) |-> dtack_n)
        else report_mismatch("dtack_n", 32'd1, 32'(dtack_n));
    assert property (@(negedge clk) disable iff (reset) (cpu_fc != 3'd7) |-> vpa_n)
        else report_mismatch("vpa_n", 32'd1, 32'(vpa_n));
    assert property (@(negedge clk) disable iff (reset) (cpu_fc == 3'd7) |-> !vpa_n)
        else report_mismatch("vpa_n", 32'd0, 32'(vpa_n));

    ////////////////////////////////////////////////////////////////////////////
    // SDRAM model and request counter

    initial begin
        logic [31:0] lat;
        lat = SEED;
        sdr_ack = 1'b0;
        sdr_q = '0;
        forever begin
            @(posedge clk);
            if (!reset && sdr_req != sdr_ack) begin
                lat = xorshift(lat);
                repeat (int'(lat % 6)) @(posedge clk);    // 1 to 6 clocks after the toggle
                sdr_ack <= sdr_req;
                sdr_q   <= sdram_word(sdr_addr);
            end
        end
    end

    initial begin
        toggles = 0;
        req_seen = 1'b0;
        forever begin
            @(negedge clk);
            if (!reset && sdr_req != req_seen) toggles++;
            req_seen = sdr_req;
        end
    end

    // One CPU cycle with peripheral hold-offs released after hold clocks
    task automatic bus_cycle(input logic [23:0] a, input logic rw, input logic [1:0] ds_n,
                             input logic [15:0] wdata, input int hold,
                             output logic [15:0] rdata);
        int n;
        @(posedge clk);
        cpu_addr     <= a[23:1];
        cpu_ds_n     <= ds_n;
        cpu_rw       <= rw;
        cpu_data_out <= wdata;
        for (n = 0; n < hold; n++) begin
            @(negedge clk);
            check_eq("dtack_n", 32'd1, 32'(dtack_n));
        end
        if (hold > 0) begin
            @(posedge clk);
            {scn_dtack_n, pri_dtack_n, obj_busy} <= 3'b000;
        end
        n = 0;
        @(negedge clk);
        while (dtack_n) begin
            if (n == TIMEOUT) report_timeout("dtack_n low in a bus cycle");
            n++;
            @(negedge clk);
        end
        rdata = cpu_data_in;
        @(posedge clk);
        cpu_ds_n <= 2'b11;
    endtask

    task automatic int_ack(input logic [2:0] level, input logic [2:0] exp_ipl);
        int n;
        @(posedge clk);
        cpu_fc   <= 3'd7;
        cpu_addr <= {20'hF_FFFF, level};
        cpu_ds_n <= 2'b10;
        n = 0;
        @(negedge clk);
        while (vpa_n) begin
            if (n == TIMEOUT) report_timeout("vpa_n low in an interrupt acknowledge");
            n++;
            @(negedge clk);
        end
        @(negedge clk);                                 // Clear lands one clock in
        check_eq("ipl_n", 32'(exp_ipl), 32'(ipl_n));
        @(posedge clk);
        cpu_ds_n <= 2'b11;
        cpu_fc   <= 3'd5;
    endtask

    initial begin
        logic [31:0]       r, d;
        logic [23:0]       a;
        logic [15:0]       q, exp;
        logic [1:0]        ds;
        logic [SDR_AW-1:0] base;
        int                hold, cnt;

        rng = SEED;
        reset = 1'b1;
        {cpu_addr, cpu_data_out} = '0;
        cpu_ds_n = 2'b11;
        cpu_rw = 1'b1;
        cpu_fc = 3'd5;
        {scn_dout, obj_dout, pri_dout, io_dout, snd_dout} = '0;
        {scn_dtack_n, pri_dtack_n, obj_busy} = 3'b000;
        vbl_n = 1'b1;
        dma_n = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_eq("ipl_n", 32'h7, 32'(ipl_n));
        check_eq("sdr_req", 32'd0, 32'(sdr_req));
        check_eq("dtack_n", 32'd1, 32'(dtack_n));

        // Peripheral reads in the order SCREEN COLOR OBJECT IO SOUND unmapped
        for (int i = 0; i < 30; i++) begin
            roll(r);
            roll(d);
            hold = (i % 6 < 3) ? 1 + int'(r[21:20]) : 0;
            @(posedge clk);
            {scn_dout, obj_dout} <= {d[15:0], d[31:16]};
            {pri_dout, io_dout, snd_dout} <= {d[23:8], d[7:0], d[27:24]};
            case (i % 6)
                0: begin
                    a = {4'h8, r[19:1], 1'b0};
                    exp = d[15:0];
                    scn_dtack_n <= 1'b1;
                end
                1: begin
                    a = {4'h2, r[19:1], 1'b0};
                    exp = d[23:8];
                    pri_dtack_n <= 1'b1;
                end
                2: begin
                    a = {4'h9, r[19:1], 1'b0};
                    exp = d[31:16];
                    obj_busy <= 1'b1;
                end
                3: begin
                    a = {8'h30, r[15:1], 1'b0};
                    exp = {8'h00, d[7:0]};
                end
                4: begin
                    a = {8'h32, r[15:1], 1'b0};
                    exp = {4'h0, d[27:24], 8'h00};
                end
                default: begin
                    a = {(r[22] ? 8'h31 : 8'hC5), r[15:1], 1'b0};
                    exp = 16'h0000;
                end
            endcase
            bus_cycle(a, 1'b1, 2'b00, 16'h0000, hold, q);
            check_eq("cpu_data_in", 32'(exp), 32'(q));
        end

        ////////////////////////////////////////////////////////////////////////////
        // ROM and work RAM through the SDRAM port

        for (int i = 0; i < 16; i++) begin
            roll(r);
            roll(d);
            base = r[20] ? WORK_BASE : ROM_BASE;
            a = {3'b000, r[20], r[19:1], 1'b0};
            ds = (r[22:21] == 2'b01) ? 2'b10 : ((r[22:21] == 2'b10) ? 2'b01 : 2'b00);
            cnt = toggles;
            bus_cycle(a, r[23], ds, d[15:0], 0, q);
            check_eq("sdr_req toggles", 32'd1, 32'(toggles - cnt));
            check_eq("sdr_addr", 32'(base + {3'b000, a}), 32'(sdr_addr));
            check_eq("sdr_be", 32'({~ds}), 32'(sdr_be));
            check_eq("sdr_rw", 32'(r[23]), 32'(sdr_rw));
            if (r[23]) begin
                check_eq("cpu_data_in", 32'(sdram_word(base + {3'b000, a})), 32'(q));
            end else begin
                check_eq("sdr_data", 32'(d[15:0]), 32'(sdr_data));
            end
        end

        // Vblank then DMA with two clocks from edge to ipl_n
        @(posedge clk);
        vbl_n <= 1'b0;
        @(negedge clk);
        @(negedge clk);
        check_eq("ipl_n", 32'h7, 32'(ipl_n));
        @(negedge clk);
        check_eq("ipl_n", 32'h2, 32'(ipl_n));
        @(posedge clk);
        vbl_n <= 1'b1;
        dma_n <= 1'b1;
        @(negedge clk);
        @(negedge clk);
        check_eq("ipl_n", 32'h2, 32'(ipl_n));
        @(negedge clk);
        check_eq("ipl_n", 32'h1, 32'(ipl_n));
        int_ack(3'd6, ~3'd5);
        int_ack(3'd5, 3'b111);

        // Edge in the same clock as its acknowledge
        @(posedge clk);
        vbl_n <= 1'b0;
        int_ack(3'd5, 3'b111);
        @(posedge clk);
        dma_n <= 1'b0;
        repeat (3) @(posedge clk);
        dma_n <= 1'b1;
        int_ack(3'd6, 3'b111);
        repeat (4) @(negedge clk);
        check_eq("ipl_n", 32'h7, 32'(ipl_n));

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: src.f
logic/f2_bus_pkg.sv
logic/cpu_addr_decoder.sv
logic/irq_controller.sv
logic/bus_responder.sv
logic/f2_cpu_bus.sv
verif/tb_f2_cpu_bus.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the CPU bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_f2_cpu_bus -f src.f -o tb_f2_cpu_bus

./obj_dir/tb_f2_cpu_bus > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST RESULT: PASS" sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
